// ==== hdl/gfx_pkg.sv ====
// ************************************************************
// gfx_pkg: display mode, framebuffer geometry and the shared
// coordinate, colour and bus types of the rectangle fill design
// ************************************************************

package gfx_pkg;

    localparam int CORDW = 16;           // coordinate width

    // small display mode, keeps simulation short
    localparam int H_ACTIVE = 64;
    localparam int H_TOTAL  = 80;
    localparam int V_ACTIVE = 36;
    localparam int V_TOTAL  = 44;
    localparam int HS_START = 66;        // hsync first pixel
    localparam int HS_END   = 71;        // hsync last pixel
    localparam int VS_START = 38;        // vsync first line
    localparam int VS_END   = 39;        // vsync last line

    // framebuffer, shown at scale 2
    localparam int FB_WIDTH  = 32;
    localparam int FB_HEIGHT = 18;
    localparam int FB_SCALE  = 2;
    localparam int FB_DEPTH  = FB_WIDTH * FB_HEIGHT;  // 576 indices
    localparam int FB_ADDRW  = $clog2(FB_DEPTH);
    localparam int CIDXW     = 4;        // colour index width
    localparam int RGBW      = 12;       // 4 bits per channel
    localparam int CHANW     = RGBW / 3;

    localparam int SHAPE_CNT = 4;        // rectangles to draw
    localparam int SHAPE_IDW = $clog2(SHAPE_CNT);

    // pacing config
    localparam int CFGW           = 16;
    localparam int FRAME_WAIT_RST = 2;   // frames before drawing starts
    localparam int PIX_FRAME_RST  = 200; // pixel budget per frame

    typedef logic signed [CORDW-1:0] coord_t;
    typedef logic [CIDXW-1:0]        cidx_t;
    typedef logic [FB_ADDRW-1:0]     fb_addr_t;

    typedef struct packed {
        logic [CHANW-1:0] r;
        logic [CHANW-1:0] g;
        logic [CHANW-1:0] b;
    } rgb_t;

    // shape descriptor, sequencer to drawer
    typedef struct packed {
        coord_t x0;
        coord_t y0;
        coord_t x1;
        coord_t y1;
        cidx_t  cidx;
    } rect_t;

    // one framebuffer write
    typedef struct packed {
        coord_t x;
        coord_t y;
        cidx_t  cidx;
    } fb_wr_t;

    typedef struct packed {
        logic hsync;
        logic vsync;
        logic de;
    } disp_t;

endpackage

// ==== hdl/display_timings.sv ====
// ************************************************************
// display_timings: raster counter for the 64x36 mode, decodes
// sync, data enable and the frame and line strobes
// ************************************************************
`timescale 1ns/1ps

module display_timings (
    input  wire logic      clk_100m,
    input  wire logic      rst,
    output gfx_pkg::coord_t sx,      // horizontal position
    output gfx_pkg::coord_t sy,      // vertical position
    output gfx_pkg::disp_t  disp,    // hsync, vsync, de
    output logic           frame,    // first pixel of a frame
    output logic           line      // first pixel of a line
);
    import gfx_pkg::*;

    logic line_end;                  // last pixel of the line
    logic frame_end;                 // last line of the frame

    assign line_end  = (sx == coord_t'(H_TOTAL - 1));
    assign frame_end = (sy == coord_t'(V_TOTAL - 1));

    always_ff @(posedge clk_100m) begin
        if (rst) begin
            sx <= '0;
            sy <= '0;
        end else if (line_end) begin
            sx <= '0;
            sy <= frame_end ? '0 : coord_t'(sy + 1);  // wrap at raster end
        end else begin
            sx <= coord_t'(sx + 1);
        end
    end

    // sync pulses are active high in this mode
    always_comb begin
        disp.hsync = (sx >= HS_START) && (sx <= HS_END);
        disp.vsync = (sy >= VS_START) && (sy <= VS_END);
        disp.de    = (sx < H_ACTIVE) && (sy < V_ACTIVE);
    end

    assign frame = (sx == '0) && (sy == '0);
    assign line  = (sx == '0);

    // raster end wraps to a frame start on a line start
    assert property (@(posedge clk_100m) disable iff (rst)
        line_end && frame_end |=> frame && line)
        else $error("raster end not followed by frame and line");

    // each line end steps to a new line
    assert property (@(posedge clk_100m) disable iff (rst)
        line_end |=> line && (sy != $past(sy)))
        else $error("line end did not move to a new line");

endmodule

// ==== hdl/framebuffer.sv ====
// ************************************************************
// framebuffer: 32x18 colour index memory, scaled scan read with
// palette lookup, write port open only in blanking
// ************************************************************
`timescale 1ns/1ps

module framebuffer (
    input  wire logic       clk_100m,
    input  wire logic       rst,
    input  gfx_pkg::coord_t sx,       // scan position
    input  gfx_pkg::coord_t sy,
    input  wire logic       de,       // scan is in active area
    input  wire logic       fb_we,    // write strobe from drawer
    input  gfx_pkg::fb_wr_t wr,       // write coords and colour
    output logic            busy,     // read port owns the memory
    output gfx_pkg::rgb_t   rgb       // palette colour, 2 cycles after sx/sy
);
    import gfx_pkg::*;

    cidx_t    fb_mem [FB_DEPTH] = '{default: '0};  // starts all black
    rgb_t     palette [2**CIDXW];
    fb_addr_t rd_addr;                // scaled scan address
    fb_addr_t wr_addr;
    logic     wr_in;                  // write lands inside the buffer
    cidx_t    rd_cidx;                // index read, stage 1
    logic     de_p1;                  // de aligned with rd_cidx

    initial begin
        $readmemh("hdl/palette.mem", palette);
    end

    // each buffer pixel covers FB_SCALE x FB_SCALE display pixels
    assign rd_addr = fb_addr_t'((sy / FB_SCALE) * FB_WIDTH + (sx / FB_SCALE));
    assign wr_addr = fb_addr_t'(wr.y * FB_WIDTH + wr.x);

    assign wr_in = (wr.x >= 0) && (wr.x < FB_WIDTH)
                && (wr.y >= 0) && (wr.y < FB_HEIGHT);

    assign busy = de;                 // display read has priority

    // single port: read in active area, write otherwise
    always_ff @(posedge clk_100m) begin
        if (de) begin
            rd_cidx <= fb_mem[rd_addr];
        end else if (fb_we && wr_in) begin
            fb_mem[wr_addr] <= wr.cidx;  // clipped writes dropped
        end
    end

    // palette lookup and output register
    always_ff @(posedge clk_100m) begin
        if (rst) begin
            de_p1 <= 1'b0;
            rgb   <= '0;
        end else begin
            de_p1 <= de;
            rgb   <= de_p1 ? palette[rd_cidx] : '0;  // black in blanking
        end
    end

    // pacer must hold off the drawer while the scan reads
    assert property (@(posedge clk_100m) disable iff (rst)
        !(fb_we && busy))
        else $error("framebuffer write while busy");

    // blanking reaches rgb after the full read latency
    assert property (@(posedge clk_100m) disable iff (rst)
        !de |-> ##2 (rgb == '0))
        else $error("rgb not black after blanking");

endmodule

// ==== hdl/draw_rectangle_fill.sv ====
// ************************************************************
// draw_rectangle_fill: steps through a filled rectangle row by
// row, one pixel per enabled cycle
// ************************************************************
`timescale 1ns/1ps

module draw_rectangle_fill (
    input  wire logic       clk_100m,
    input  wire logic       rst,
    input  wire logic       start,    // latch corners, begin
    input  wire logic       oe,       // output enable, one pixel per cycle
    input  gfx_pkg::rect_t  rect,     // corners, only read on start
    output gfx_pkg::coord_t x,        // current pixel
    output gfx_pkg::coord_t y,
    output logic            drawing,  // x/y valid this cycle
    output logic            done      // pulse after last pixel
);
    import gfx_pkg::*;

    coord_t x0_r;                     // row restart column
    coord_t x1_r;                     // last column
    coord_t y1_r;                     // last row
    logic   active;                   // pixels remain
    logic   last_col;
    logic   last_pix;

    assign last_col = (x == x1_r);
    assign last_pix = last_col && (y == y1_r);
    assign drawing  = active && oe;   // stall when oe low

    // position and corners
    always_ff @(posedge clk_100m) begin
        if (start) begin
            x    <= rect.x0;
            y    <= rect.y0;
            x0_r <= rect.x0;
            x1_r <= rect.x1;
            y1_r <= rect.y1;
        end else if (drawing) begin
            if (last_col) begin
                x <= x0_r;            // next row
                y <= coord_t'(y + 1);
            end else begin
                x <= coord_t'(x + 1);
            end
        end
    end

    // control
    always_ff @(posedge clk_100m) begin
        if (rst) begin
            active <= 1'b0;
            done   <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                active <= 1'b1;
            end else if (drawing && last_pix) begin
                active <= 1'b0;
                done   <= 1'b1;       // one cycle after final pixel
            end
        end
    end

    // a stalled drawer keeps its pixel
    assert property (@(posedge clk_100m) disable iff (rst)
        active && !oe |=> $stable(x) && $stable(y))
        else $error("drawer moved without output enable");

    // only one rectangle in flight
    assert property (@(posedge clk_100m) disable iff (rst)
        start |-> !active)
        else $error("start while a rectangle is still drawing");

endmodule

// ==== hdl/shape_sequencer.sv ====
// ************************************************************
// shape_sequencer: launches each rectangle in turn, geometry
// derived from the shape id
// ************************************************************
`timescale 1ns/1ps

module shape_sequencer (
    input  wire logic      clk_100m,
    input  wire logic      rst,
    input  wire logic      frame,     // first frame kicks things off
    input  wire logic      done,      // current rectangle finished
    output logic           start,     // one-cycle launch pulse
    output gfx_pkg::rect_t rect,      // held steady while drawing
    output logic           all_done
);
    import gfx_pkg::*;

    typedef enum logic [1:0] {IDLE, INIT, DRAW, DONE} state_t;

    state_t               state;
    logic [SHAPE_IDW-1:0] shape_id;

    always_ff @(posedge clk_100m) begin
        if (rst) begin
            state    <= IDLE;
            shape_id <= '0;
        end else begin
            case (state)
                IDLE: if (frame) state <= INIT;
                INIT: state <= DRAW;  // start goes out this cycle
                DRAW: begin
                    if (done) begin
                        if (shape_id == SHAPE_IDW'(SHAPE_CNT - 1)) begin
                            state <= DONE;
                        end else begin
                            shape_id <= shape_id + 1'b1;
                            state    <= INIT;
                        end
                    end
                end
                DONE: state <= DONE;  // stays until reset
                default: state <= IDLE;
            endcase
        end
    end

    // 11x8 rectangles stepping down and right
    always_comb begin
        rect.x0   = coord_t'(4 + 3 * shape_id);
        rect.y0   = coord_t'(2 + 2 * shape_id);
        rect.x1   = coord_t'(14 + 3 * shape_id);
        rect.y1   = coord_t'(9 + 2 * shape_id);
        rect.cidx = cidx_t'(shape_id + 1);  // entry 0 is black
    end

    assign start    = (state == INIT);
    assign all_done = (state == DONE);

    // the drawer only finishes a launched rectangle
    assert property (@(posedge clk_100m) disable iff (rst)
        done |-> (state == DRAW))
        else $error("done pulse outside DRAW");

endmodule

// ==== hdl/draw_pacer.sv ====
// ************************************************************
// draw_pacer: frame_wait and pix_per_frame registers, gates the
// drawer to a pixel budget per frame in blanking only
// ************************************************************
`timescale 1ns/1ps

module draw_pacer (
    input  wire logic                     clk_100m,
    input  wire logic                     rst,
    input  wire logic                     cfg_we,     // config write strobe
    input  wire logic                     cfg_addr,   // 0 frame_wait, 1 pix_per_frame
    input  wire logic [gfx_pkg::CFGW-1:0] cfg_wdata,
    input  wire logic                     frame,
    input  wire logic                     busy,       // framebuffer scanning
    output logic                          draw_oe
);
    import gfx_pkg::*;

    logic [CFGW-1:0] frame_wait;      // frames before drawing
    logic [CFGW-1:0] pix_per_frame;   // pixel budget
    logic [CFGW-1:0] cnt_frame;       // frames seen, saturates
    logic [CFGW-1:0] cnt_pix;         // pixels this frame
    logic            wait_over;

    always_ff @(posedge clk_100m) begin
        if (rst) begin
            frame_wait    <= CFGW'(FRAME_WAIT_RST);
            pix_per_frame <= CFGW'(PIX_FRAME_RST);
        end else if (cfg_we) begin
            if (cfg_addr) pix_per_frame <= cfg_wdata;
            else          frame_wait    <= cfg_wdata;
        end
    end

    assign wait_over = (cnt_frame >= frame_wait);
    assign draw_oe   = wait_over && (cnt_pix < pix_per_frame) && !busy;

    always_ff @(posedge clk_100m) begin
        if (rst) begin
            cnt_frame <= '0;
            cnt_pix   <= '0;
        end else begin
            // a new frame_wait restarts the wait
            if (cfg_we && !cfg_addr) cnt_frame <= '0;
            else if (frame && !wait_over) cnt_frame <= cnt_frame + 1'b1;

            if (frame) cnt_pix <= '0;  // fresh budget each frame
            else if (draw_oe) cnt_pix <= cnt_pix + 1'b1;
        end
    end

    assert property (@(posedge clk_100m) disable iff (rst)
        cnt_pix <= pix_per_frame)
        else $error("pixel count over budget");

endmodule

// ==== hdl/rect_fill_top.sv ====
// ************************************************************
// rect_fill_top: paced rectangle drawing into the framebuffer,
// scanned out with display controls aligned to rgb
// ************************************************************
`timescale 1ns/1ps

module rect_fill_top (
    input  wire logic                     clk_100m,
    input  wire logic                     rst,
    input  wire logic                     cfg_we,
    input  wire logic                     cfg_addr,
    input  wire logic [gfx_pkg::CFGW-1:0] cfg_wdata,
    output gfx_pkg::disp_t                disp,      // delayed to match rgb
    output gfx_pkg::rgb_t                 rgb,
    output logic                          all_done
);
    import gfx_pkg::*;

    coord_t sx, sy;                   // scan position
    disp_t  disp_raw;                 // controls at scan time
    disp_t  disp_p1;                  // after memory read stage
    logic   frame;
    logic   busy;
    logic   draw_oe;
    logic   draw_start, drawing, draw_done;
    rect_t  rect;
    coord_t draw_x, draw_y;
    fb_wr_t fb_wr;

    display_timings timings0 (
        .clk_100m, .rst, .sx, .sy, .disp(disp_raw), .frame,
        .line()                       // not needed at this level
    );

    shape_sequencer seq0 (
        .clk_100m, .rst, .frame, .done(draw_done),
        .start(draw_start), .rect, .all_done
    );

    draw_pacer pacer0 (
        .clk_100m, .rst, .cfg_we, .cfg_addr, .cfg_wdata,
        .frame, .busy, .draw_oe
    );

    draw_rectangle_fill draw0 (
        .clk_100m, .rst, .start(draw_start), .oe(draw_oe), .rect,
        .x(draw_x), .y(draw_y), .drawing, .done(draw_done)
    );

    assign fb_wr = '{x: draw_x, y: draw_y, cidx: rect.cidx};  // colour held by sequencer

    framebuffer fb0 (
        .clk_100m, .rst, .sx, .sy, .de(disp_raw.de),
        .fb_we(drawing), .wr(fb_wr), .busy, .rgb
    );

    // two stages: memory read, then palette register
    always_ff @(posedge clk_100m) begin
        if (rst) begin
            disp_p1 <= '0;
            disp    <= '0;
        end else begin
            disp_p1 <= disp_raw;
            disp    <= disp_p1;
        end
    end

endmodule

// ==== tb/rect_fill_tb.sv ====
// ************************************************************
// rect_fill_tb: paces the rectangle fill top, rebuilds the image
// from the scan output and checks it against a model
// ************************************************************
`timescale 1ns/1ps

module rect_fill_tb;
    import gfx_pkg::*;

    localparam int WAIT_FRAMES = 3;               // frame_wait to write
    localparam int PIX_BUDGET  = 50;              // pix_per_frame to write
    localparam int RECT_PIX    = 11 * 8;          // pixels per shape
    localparam int DRAW_FRAMES = (SHAPE_CNT * RECT_PIX + PIX_BUDGET - 1) / PIX_BUDGET;
    localparam int FRAME_NS    = H_TOTAL * V_TOTAL * 10;
    localparam int NTESTS      = 6;
    localparam int T_RASTER = 0, T_BLANK = 1, T_WAIT = 2, T_PACE = 3, T_FINAL = 4, T_DONE = 5;

    logic            clk_100m = 1'b0;
    logic            rst;
    logic            cfg_we;
    logic            cfg_addr;
    logic [CFGW-1:0] cfg_wdata;
    disp_t           disp;
    rgb_t            rgb;
    logic            all_done;

    // colours as listed in hdl/palette.mem
    logic [RGBW-1:0] pal [16] = '{12'h000, 12'hF00, 12'h0F0, 12'h00F, 12'hFF0, 12'h0FF,
        12'hF0F, 12'hFFF, 12'h888, 12'h800, 12'h080, 12'h008, 12'h880, 12'h088, 12'h808, 12'h444};
    logic [CIDXW-1:0] model_idx   [FB_HEIGHT][FB_WIDTH];  // expected indices
    logic [RGBW-1:0]  shadow      [FB_HEIGHT][FB_WIDTH];  // image seen this frame
    logic [RGBW-1:0]  shadow_prev [FB_HEIGHT][FB_WIDTH];
    int    errs [NTESTS];
    string test_name [NTESTS] = '{"raster", "blanking", "frame_wait", "pacing",
        "final_image", "completion"};
    int    ox, oy;                // output raster position
    int    hs_cnt;                // hsync pulses since last vsync
    int    fi;                    // output frame index, config lands in frame 0
    int    done_fi;               // frame where all_done rose
    logic  prev_de, prev_hs, prev_vs, prev_all_done;
    logic  done_seen, final_checked;

    rect_fill_top dut0 (
        .clk_100m, .rst, .cfg_we, .cfg_addr, .cfg_wdata, .disp, .rgb, .all_done
    );

    always #5 clk_100m = ~clk_100m;

    task automatic log_mismatch(input int id, input string msg);
        $display("MISMATCH at %0t ns: %s", $time, msg);
        errs[id]++;
    endtask

    task automatic log_error(input int id, input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        errs[id]++;
    endtask

    task automatic report_test(input int id);
        if (errs[id] == 0) $display("test %s: passed", test_name[id]);
        else $display("test %s: failed, %0d errors", test_name[id], errs[id]);
    endtask

    // shape i spans x 4+3i..14+3i, y 2+2i..9+2i, later shapes on top
    task automatic build_model();
        for (int y = 0; y < FB_HEIGHT; y++)
            for (int x = 0; x < FB_WIDTH; x++) model_idx[y][x] = '0;
        for (int i = 0; i < SHAPE_CNT; i++)
            for (int y = 2 + 2 * i; y <= 9 + 2 * i; y++)
                for (int x = 4 + 3 * i; x <= 14 + 3 * i; x++) model_idx[y][x] = CIDXW'(i + 1);
    endtask

    function automatic int count_changes();
        int n;
        n = 0;
        for (int y = 0; y < FB_HEIGHT; y++)
            for (int x = 0; x < FB_WIDTH; x++) if (shadow[y][x] != shadow_prev[y][x]) n++;
        return n;
    endfunction

    // outputs settle after the rising edge, sampled mid-cycle
    always @(negedge clk_100m) begin
        logic [RGBW-1:0] px;
        int              changed;
        px = rgb;
        if (!rst) begin
            if (disp.hsync && !prev_hs) hs_cnt++;
            if (disp.de) begin
                if (ox == 0 && oy == 0) begin
                    fi++;                                  // new output frame
                    if (fi == WAIT_FRAMES) report_test(T_WAIT);
                end
                if (ox % 2 == 0 && oy % 2 == 0) shadow[oy / 2][ox / 2] = px;
                if (fi < WAIT_FRAMES)
                    assert (px == '0) else log_mismatch(T_WAIT, $sformatf(
                        "pixel (%0d,%0d) in frame %0d is %h before wait", ox, oy, fi, px));
                if (done_seen && fi == done_fi + 2)      // one full frame after all_done
                    assert (px == pal[model_idx[oy / 2][ox / 2]]) else log_mismatch(T_FINAL,
                        $sformatf("pixel (%0d,%0d) is %h, expected %h", ox, oy, px,
                        pal[model_idx[oy / 2][ox / 2]]));
                ox++;
            end else begin
                assert (px == '0) else log_mismatch(T_BLANK, $sformatf("rgb %h in blanking", px));
                if (prev_de) begin
                    assert (ox == H_ACTIVE) else log_error(T_RASTER,
                        $sformatf("line %0d had %0d de cycles", oy, ox));
                    ox = 0;
                    oy++;
                end
            end
            if (disp.vsync && !prev_vs) begin             // end of active area
                assert (oy == V_ACTIVE) else log_error(T_RASTER,
                    $sformatf("frame %0d had %0d active lines", fi, oy));
                if (fi > 0) begin
                    assert (hs_cnt == V_TOTAL) else log_error(T_RASTER,
                        $sformatf("frame %0d had %0d hsync pulses", fi, hs_cnt));
                    changed = count_changes();
                    assert (changed <= PIX_BUDGET) else log_error(T_PACE,
                        $sformatf("%0d pixels changed in frame %0d, budget %0d", changed, fi,
                        PIX_BUDGET));
                end
                shadow_prev = shadow;
                hs_cnt = 0;
                oy = 0;
                if (done_seen && fi == done_fi + 2) begin
                    report_test(T_FINAL);
                    final_checked = 1'b1;
                end
            end
            if (all_done && !prev_all_done) begin
                assert (fi + 1 >= WAIT_FRAMES + DRAW_FRAMES) else log_error(T_DONE,
                    $sformatf("all_done rose too early, in frame %0d", fi));
                done_seen = 1'b1;
                done_fi = fi;
                report_test(T_DONE);
            end
            prev_de = disp.de;
            prev_hs = disp.hsync;
            prev_vs = disp.vsync;
            prev_all_done = all_done;
        end
    end

    initial begin
        int total;
        int failed;
        rst = 1'b1;
        cfg_we = 1'b0;
        cfg_addr = 1'b0;
        cfg_wdata = '0;
        {ox, oy, hs_cnt, done_fi} = '0;
        fi = -1;                                           // first frame start makes 0
        {prev_de, prev_hs, prev_vs, prev_all_done, done_seen, final_checked} = '0;
        foreach (errs[i]) errs[i] = 0;
        build_model();
        repeat (8) @(posedge clk_100m);
        rst <= 1'b0;
        @(posedge clk_100m);
        cfg_we <= 1'b1;                                    // frame_wait
        cfg_addr <= 1'b0;
        cfg_wdata <= CFGW'(WAIT_FRAMES);
        @(posedge clk_100m);
        cfg_addr <= 1'b1;                                  // pix_per_frame
        cfg_wdata <= CFGW'(PIX_BUDGET);
        @(posedge clk_100m);
        cfg_we <= 1'b0;
        wait (final_checked);
        report_test(T_RASTER);
        report_test(T_BLANK);
        report_test(T_PACE);
        total = 0;
        failed = 0;
        foreach (errs[i]) begin
            total += errs[i];
            if (errs[i] != 0) failed++;
        end
        $display("summary: %0d tests, %0d failed, %0d errors", NTESTS, failed, total);
        if (total == 0) $display("Done: no errors");
        else $display("Done: errors found");
        $finish;
    end

    // drawing plus the final frame fit well inside 20 frames
    initial begin
        #(20 * FRAME_NS);
        $display("watchdog: final image frame not reached within 20 frames");
        $display("Done: errors found");
        $finish;
    end

endmodule

// ==== hdl/palette.mem ====
// one 12-bit rgb value per colour index, red green blue nibbles
000
F00
0F0
00F
FF0
0FF
F0F
FFF
888
800
080
008
880
088
808
444

// ==== sim.f ====
hdl/gfx_pkg.sv
hdl/display_timings.sv
hdl/framebuffer.sv
hdl/draw_rectangle_fill.sv
hdl/shape_sequencer.sv
hdl/draw_pacer.sv
hdl/rect_fill_top.sv
tb/rect_fill_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the rectangle fill testbench with Verilator, from the project root
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module rect_fill_tb \
    -f sim.f -o rect_fill_sim > build.log 2>&1 \
    && ./obj_dir/rect_fill_sim > sim.log 2>&1 \
    || echo "simulation exited with an error status" >> sim.log
cat build.log sim.log 2>/dev/null
! grep -q "Done: errors found" sim.log && grep -q "Done: no errors" sim.log
